//--- source/storeBufferGeomPkg.sv
// Store buffer geometry package: bank sizes, field widths and the stored entry layout
`default_nettype none

package storeBufferGeomPkg;

    // Entries per bank
    localparam int unsigned bankDepth = 4;

    // One sequential bank and one boosted bank
    localparam int unsigned numBanks = 2;

    // Store payload widths
    localparam int unsigned addrWidth = 32;
    localparam int unsigned dataWidth = 32;
    localparam int unsigned maskWidth = 4;

    // Names one of the two banks
    typedef logic bankIdx;

    // One-hot entry pointer, rotates left on every advance
    typedef logic [bankDepth-1:0] entryPtr;

    // Pointer value after reset or clear, entry 0
    localparam entryPtr firstEntry = entryPtr'(1);

    // ---------------------------------------------------------------------
    // One buffered store
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic [maskWidth-1:0] mask;
    } storeEntry;

endpackage

`default_nettype wire

//--- source/storeBufferCtrlPkg.sv
// Store buffer control package: bank roles and memory exception causes
`default_nettype none

package storeBufferCtrlPkg;

    // ---------------------------------------------------------------------
    // Bank roles
    // ---------------------------------------------------------------------

    // Bank 0 holds the sequential stores out of reset
    // The other bank starts out as the boosted one
    localparam storeBufferGeomPkg::bankIdx resetSeqBank = 1'b0;

    // ---------------------------------------------------------------------
    // Memory exception causes
    // ---------------------------------------------------------------------

    // Registered one cycle after the offending store or load
    // none keeps memExcept low
    // bufferFull is a store aimed at a full bank, store dropped
    // boostConflict is a boosted load that hits the boosted bank
    typedef enum logic [1:0] {
        none          = 2'd0,
        bufferFull    = 2'd1,
        boostConflict = 2'd2
    } exceptCause;

endpackage

`default_nettype wire

//--- source/storeRouter.sv
// Store router: bank roles, store steering, commit and squash handling, load checks
`timescale 1ns/100ps
`default_nettype none

module storeRouter (
    input  logic                                     phi1,
    input  logic                                     rst,
    input  logic                                     stall,
    input  logic                                     storeValid,
    input  logic                                     storeBoosted,
    input  logic                                     loadValid,
    input  logic                                     loadBoosted,
    input  logic                                     commit,
    input  logic                                     squash,
    input  logic                                     except,
    input  logic [storeBufferGeomPkg::numBanks-1:0]  bankFull,
    input  logic [storeBufferGeomPkg::numBanks-1:0]  bankEmpty,
    input  logic [storeBufferGeomPkg::numBanks-1:0]  bankMatch,
    output logic [storeBufferGeomPkg::numBanks-1:0]  bankWrite,
    output logic [storeBufferGeomPkg::numBanks-1:0]  bankClear,
    output storeBufferGeomPkg::bankIdx               seqBank,
    output logic                                     seqConflict,
    output logic                                     memExcept,
    output logic                                     bufferStall
);

    import storeBufferGeomPkg::*;
    import storeBufferCtrlPkg::*;

    bankIdx     boostBank;
    bankIdx     targetBank;
    logic       storeTake;
    logic       targetFull;
    logic       storeGo;
    logic       seqStoreGo;
    logic       clearBoost;
    logic       commitReq;
    logic       commitOk;
    logic       storeFullHit;
    logic       boostLoadHit;
    exceptCause causeNext;
    exceptCause causeQ;

    // ---------------------------------------------------------------------
    // Store steering
    // ---------------------------------------------------------------------
    assign boostBank  = ~seqBank;
    assign targetBank = storeBoosted ? boostBank : seqBank;
    assign targetFull = bankFull[targetBank];

    // Stall and a global exception both drop the store
    assign storeTake = storeValid & ~stall & ~except;

    // Squash or exception empties the boosted bank
    assign clearBoost = except | (squash & ~stall);

    // A boosted store racing a boosted clear is squashed with it
    assign storeGo    = storeTake & ~targetFull & ~(storeBoosted & clearBoost);
    assign seqStoreGo = storeGo & ~storeBoosted;

    always_comb begin
        for (int i = 0; i < numBanks; i++) begin
            bankWrite[i] = storeGo & (targetBank == bankIdx'(i));
            bankClear[i] = clearBoost & (boostBank == bankIdx'(i));
        end
    end

    // ---------------------------------------------------------------------
    // Commit, the role swap
    // ---------------------------------------------------------------------
    assign commitReq = commit & ~stall;

    // Sequential bank must be empty, and stay empty this cycle
    assign bufferStall = commitReq & (~bankEmpty[seqBank] | seqStoreGo);

    // Commit loses against a squash or exception in the same cycle
    assign commitOk = commitReq & ~bufferStall & ~squash & ~except;

    always_ff @(posedge phi1) begin
        if (rst) begin
            seqBank <= resetSeqBank;
        end else if (commitOk) begin
            // Old boosted bank turns sequential
            seqBank <= boostBank;
        end
    end

    // ---------------------------------------------------------------------
    // Load checks and memory exception
    // ---------------------------------------------------------------------

    // Pipeline stalls on a hit in the sequential bank
    assign seqConflict = loadValid & bankMatch[seqBank];

    assign storeFullHit = storeTake & targetFull;
    assign boostLoadHit = loadValid & loadBoosted & ~stall & bankMatch[boostBank];

    always_comb begin
        causeNext = none;
        if (storeFullHit) begin
            causeNext = bufferFull;
        end else if (boostLoadHit) begin
            causeNext = boostConflict;
        end
    end

    // One cycle pulse after the offending cycle
    always_ff @(posedge phi1) begin
        if (rst) begin
            causeQ <= none;
        end else begin
            causeQ <= causeNext;
        end
    end

    assign memExcept = (causeQ != none);

endmodule

`default_nettype wire

//--- source/storeBufferBank.sv
// Store buffer bank holding four stores in a circular buffer with one-hot pointers and load match
`timescale 1ns/100ps
`default_nettype none

module storeBufferBank (
    input  logic                                     phi1,
    input  logic                                     rst,
    input  logic                                     clear,
    input  logic                                     write,
    input  logic                                     pop,
    input  logic [storeBufferGeomPkg::addrWidth-1:0] writeAddr,
    input  logic [storeBufferGeomPkg::dataWidth-1:0] writeData,
    input  logic [storeBufferGeomPkg::maskWidth-1:0] writeMask,
    input  logic [storeBufferGeomPkg::addrWidth-1:0] loadAddr,
    output logic                                     full,
    output logic                                     empty,
    output logic                                     match,
    output logic [storeBufferGeomPkg::addrWidth-1:0] headAddr,
    output logic [storeBufferGeomPkg::dataWidth-1:0] headData,
    output logic [storeBufferGeomPkg::maskWidth-1:0] headMask
);

    import storeBufferGeomPkg::*;

    // Entry storage
    storeEntry entryQ [bankDepth];

    // headQ is the first free entry, tailQ the oldest one
    entryPtr   headQ;
    entryPtr   tailQ;
    entryPtr   validQ;
    entryPtr   matchVec;
    storeEntry oldest;
    logic      doWrite;
    logic      doPop;

    // Guard against overfill and underflow
    assign doWrite = write & ~full;
    assign doPop   = pop & ~empty;

    // ---------------------------------------------------------------------
    // Status
    // ---------------------------------------------------------------------

    // Pointers meet when all four entries are taken
    assign full  = (headQ == tailQ) & (|validQ);
    assign empty = ~(|validQ);

    // ---------------------------------------------------------------------
    // Pointers and valid bits
    // ---------------------------------------------------------------------
    always_ff @(posedge phi1) begin
        if (rst || clear) begin
            headQ  <= firstEntry;
            tailQ  <= firstEntry;
            validQ <= '0;
        end else begin
            if (doWrite) begin
                headQ <= {headQ[bankDepth-2:0], headQ[bankDepth-1]};
            end
            if (doPop) begin
                tailQ <= {tailQ[bankDepth-2:0], tailQ[bankDepth-1]};
            end
            // Pop drops the oldest bit, write sets the head bit
            validQ <= (validQ & ~({bankDepth{doPop}} & tailQ)) |
                      ({bankDepth{doWrite}} & headQ);
        end
    end

    // Store lands in the entry under the head pointer
    always_ff @(posedge phi1) begin
        for (int k = 0; k < bankDepth; k++) begin
            if (doWrite && headQ[k]) begin
                entryQ[k] <= '{addr: writeAddr, data: writeData, mask: writeMask};
            end
        end
    end

    // ---------------------------------------------------------------------
    // Load match and oldest entry select
    // ---------------------------------------------------------------------
    always_comb begin
        matchVec = '0;
        oldest   = entryQ[0];
        for (int k = 0; k < bankDepth; k++) begin
            // Parallel compare over valid entries
            matchVec[k] = validQ[k] & (entryQ[k].addr == loadAddr);
            if (tailQ[k]) begin
                oldest = entryQ[k];
            end
        end
    end

    assign match = |matchVec;

    // Head toward memory is the oldest entry, not the write pointer
    assign headAddr = oldest.addr;
    assign headData = oldest.data;
    assign headMask = oldest.mask;

endmodule

`default_nettype wire

//--- source/retireSelect.sv
// Retire select: drains the sequential bank's oldest store to the memory write port
`timescale 1ns/100ps
`default_nettype none

module retireSelect (
    input  logic                                                  phi1,
    input  logic                                                  rst,
    input  logic                                                  memReady,
    input  storeBufferGeomPkg::bankIdx                            seqBank,
    input  logic [storeBufferGeomPkg::numBanks-1:0]               bankEmpty,
    input  logic [storeBufferGeomPkg::numBanks-1:0]
                 [storeBufferGeomPkg::addrWidth-1:0]              headAddr,
    input  logic [storeBufferGeomPkg::numBanks-1:0]
                 [storeBufferGeomPkg::dataWidth-1:0]              headData,
    input  logic [storeBufferGeomPkg::numBanks-1:0]
                 [storeBufferGeomPkg::maskWidth-1:0]              headMask,
    output logic [storeBufferGeomPkg::numBanks-1:0]               bankPop,
    output logic                                                  memWriteValid,
    output logic [storeBufferGeomPkg::addrWidth-1:0]              memWriteAddr,
    output logic [storeBufferGeomPkg::dataWidth-1:0]              memWriteData,
    output logic [storeBufferGeomPkg::maskWidth-1:0]              memWriteMask
);

    import storeBufferGeomPkg::*;
    import storeBufferCtrlPkg::*;

    logic   holdQ;
    bankIdx holdBankQ;
    bankIdx selBank;
    logic   accept;

    // Presented but unaccepted entry keeps its bank
    assign selBank = holdQ ? holdBankQ : seqBank;

    // ---------------------------------------------------------------------
    // Memory port
    // ---------------------------------------------------------------------
    assign memWriteValid = ~bankEmpty[selBank];
    assign memWriteAddr  = headAddr[selBank];
    assign memWriteData  = headData[selBank];
    assign memWriteMask  = headMask[selBank];

    // Pop on the edge where valid and ready meet
    assign accept = memWriteValid & memReady;

    always_comb begin
        for (int i = 0; i < numBanks; i++) begin
            bankPop[i] = accept & (selBank == bankIdx'(i));
        end
    end

    // Hold flag set while back-pressure keeps an entry waiting
    always_ff @(posedge phi1) begin
        if (rst) begin
            holdQ     <= 1'b0;
            holdBankQ <= resetSeqBank;
        end else begin
            holdQ     <= memWriteValid & ~memReady;
            holdBankQ <= selBank;
        end
    end

endmodule

`default_nettype wire

//--- source/storeBufferTop.sv
// Store buffer top: router, two banks and the retire path to memory
`timescale 1ns/100ps
`default_nettype none

module storeBufferTop (
    input  logic                                     phi1,
    input  logic                                     rst,
    input  logic                                     stall,
    input  logic                                     storeValid,
    input  logic                                     storeBoosted,
    input  logic [storeBufferGeomPkg::addrWidth-1:0] storeAddr,
    input  logic [storeBufferGeomPkg::dataWidth-1:0] storeData,
    input  logic [storeBufferGeomPkg::maskWidth-1:0] storeMask,
    input  logic                                     loadValid,
    input  logic                                     loadBoosted,
    input  logic [storeBufferGeomPkg::addrWidth-1:0] loadAddr,
    input  logic                                     commit,
    input  logic                                     squash,
    input  logic                                     except,
    input  logic                                     memReady,
    output logic                                     memWriteValid,
    output logic [storeBufferGeomPkg::addrWidth-1:0] memWriteAddr,
    output logic [storeBufferGeomPkg::dataWidth-1:0] memWriteData,
    output logic [storeBufferGeomPkg::maskWidth-1:0] memWriteMask,
    output logic                                     seqConflict,
    output logic                                     memExcept,
    output logic                                     bufferStall
);

    import storeBufferGeomPkg::*;

    logic [numBanks-1:0]                bankWrite;
    logic [numBanks-1:0]                bankClear;
    logic [numBanks-1:0]                bankPop;
    logic [numBanks-1:0]                bankFull;
    logic [numBanks-1:0]                bankEmpty;
    logic [numBanks-1:0]                bankMatch;
    logic [numBanks-1:0][addrWidth-1:0] headAddr;
    logic [numBanks-1:0][dataWidth-1:0] headData;
    logic [numBanks-1:0][maskWidth-1:0] headMask;
    bankIdx                             seqBank;

    // Roles, steering and exceptions
    storeRouter u_storeRouter (
        .phi1(phi1), .rst(rst), .stall(stall),
        .storeValid(storeValid), .storeBoosted(storeBoosted),
        .loadValid(loadValid), .loadBoosted(loadBoosted),
        .commit(commit), .squash(squash), .except(except),
        .bankFull(bankFull), .bankEmpty(bankEmpty), .bankMatch(bankMatch),
        .bankWrite(bankWrite), .bankClear(bankClear), .seqBank(seqBank),
        .seqConflict(seqConflict), .memExcept(memExcept), .bufferStall(bufferStall)
    );

    // Both banks share the store and load buses
    for (genvar i = 0; i < numBanks; i++) begin : gBank
        storeBufferBank u_bank (
            .phi1(phi1), .rst(rst), .clear(bankClear[i]),
            .write(bankWrite[i]), .pop(bankPop[i]),
            .writeAddr(storeAddr), .writeData(storeData), .writeMask(storeMask),
            .loadAddr(loadAddr),
            .full(bankFull[i]), .empty(bankEmpty[i]), .match(bankMatch[i]),
            .headAddr(headAddr[i]), .headData(headData[i]), .headMask(headMask[i])
        );
    end

    // Drain of the sequential bank
    retireSelect u_retireSelect (
        .phi1(phi1), .rst(rst), .memReady(memReady), .seqBank(seqBank),
        .bankEmpty(bankEmpty), .headAddr(headAddr), .headData(headData),
        .headMask(headMask), .bankPop(bankPop), .memWriteValid(memWriteValid),
        .memWriteAddr(memWriteAddr), .memWriteData(memWriteData),
        .memWriteMask(memWriteMask)
    );

endmodule

`default_nettype wire

//--- tests/storeBuffer_asserts.sv
// Store buffer assertions on bank write and clear exclusion, memory port hold and reset exit
`timescale 1ns/100ps
`default_nettype none

module storeBuffer_asserts (
    input logic                                     phi1,
    input logic                                     rst,
    input logic [storeBufferGeomPkg::numBanks-1:0]  bankWrite,
    input logic [storeBufferGeomPkg::numBanks-1:0]  bankClear,
    input logic                                     memReady,
    input logic                                     memWriteValid,
    input logic [storeBufferGeomPkg::addrWidth-1:0] memWriteAddr,
    input logic [storeBufferGeomPkg::dataWidth-1:0] memWriteData,
    input logic [storeBufferGeomPkg::maskWidth-1:0] memWriteMask,
    input logic                                     memExcept
);

    // Count of failed assertions
    int unsigned failCount = 0;

    // A bank is never written and cleared in one cycle
    writeClearApart: assert property (@(posedge phi1) disable iff (rst)
        (bankWrite & bankClear) == '0)
    else begin
        failCount++;
        $error("bank written and cleared in the same cycle");
    end

    // Presented write holds until memReady
    holdUntilReady: assert property (@(posedge phi1) disable iff (rst)
        memWriteValid && !memReady |=> memWriteValid && $stable(memWriteAddr) &&
        $stable(memWriteData) && $stable(memWriteMask))
    else begin
        failCount++;
        $error("memory write changed while memReady was low");
    end

    // First cycle out of reset
    quietAfterReset: assert property (@(posedge phi1) $fell(rst) |-> !memExcept)
    else begin
        failCount++;
        $error("memExcept high right after reset");
    end

endmodule

`default_nettype wire

//--- tests/storeBufferTb.sv
// Store buffer testbench with directed tests against a queue model of both bank roles
`timescale 1ns/100ps
`default_nettype none

module storeBufferTb;

    import storeBufferGeomPkg::*;

    logic                 phi1 = 1'b0;
    logic                 rst;
    logic                 stall, storeValid, storeBoosted, loadValid, loadBoosted;
    logic                 commit, squash, except, memReady;
    logic [addrWidth-1:0] storeAddr, loadAddr, memWriteAddr;
    logic [dataWidth-1:0] storeData, memWriteData;
    logic [maskWidth-1:0] storeMask, memWriteMask;
    logic                 memWriteValid, seqConflict, memExcept, bufferStall;

    // Expected contents of each role in age order
    storeEntry   seqModel[$];
    storeEntry   boostModel[$];
    storeEntry   lastOut;
    logic        lastWait = 1'b0;
    logic [31:0] rngState = 32'd46;
    logic [31:0] readyRng = 32'd46;
    logic        readyLevel, jitter, jitterReady = 1'b0;
    int          stretch = 0;
    int          errors = 0, testErrors = 0, monErrors = 0, monMark = 0;
    int          testCount = 0, failedTests = 0;
    string       testName;

    always #5 phi1 = ~phi1;

    // Random ready stretches only while jitter is on
    assign memReady = jitter ? jitterReady : readyLevel;

    storeBufferTop u_storeBufferTop (.*);

    bind storeBufferTop storeBuffer_asserts u_asserts (
        .phi1(phi1), .rst(rst), .bankWrite(bankWrite), .bankClear(bankClear),
        .memReady(memReady), .memWriteValid(memWriteValid), .memWriteAddr(memWriteAddr),
        .memWriteData(memWriteData), .memWriteMask(memWriteMask), .memExcept(memExcept)
    );

    function automatic logic [31:0] xorshift(inout logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic compareWrite(input storeEntry exp, input logic [addrWidth-1:0] addr,
                                input logic [dataWidth-1:0] data,
                                input logic [maskWidth-1:0] mask);
        if (addr !== exp.addr || data !== exp.data || mask !== exp.mask) begin
            $display("[ERROR] %s: write expected %h %h %h, actual %h %h %h", testName,
                     exp.addr, exp.data, exp.mask, addr, data, mask);
            monErrors++;
        end
    endtask

    task automatic compareFlag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %b, actual %b", testName, what, exp, act);
            testErrors++;
        end
    endtask

    // Memory port monitor that pops the model on every accepted write
    always @(posedge phi1) begin
        if (rst) begin
            lastWait = 1'b0;
        end else begin
            if (lastWait && (!memWriteValid ||
                {memWriteAddr, memWriteData, memWriteMask} !== lastOut)) begin
                $display("%s: memory write dropped or changed before acceptance", testName);
                monErrors++;
            end
            if (memWriteValid && memReady) begin
                if (seqModel.size() == 0) begin
                    $display("%s: memory write with no sequential store pending", testName);
                    monErrors++;
                end else begin
                    compareWrite(seqModel.pop_front(), memWriteAddr, memWriteData, memWriteMask);
                end
            end
            lastWait = memWriteValid && !memReady;
            lastOut  = {memWriteAddr, memWriteData, memWriteMask};
        end
    end

    // Toggle ready after a random number of cycles
    always @(negedge phi1) begin
        if (jitter) begin
            if (stretch <= 0) begin
                jitterReady = ~jitterReady;
                stretch     = int'(xorshift(readyRng) % 5) + 1;
            end
            stretch--;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------

    // Target bank full means the store is dropped and memExcept follows
    task automatic pushStore(input logic boosted, input logic [addrWidth-1:0] addr);
        storeEntry   e;
        logic        fits;
        logic [31:0] rnd;
        @(negedge phi1);
        rnd    = xorshift(rngState);
        e.addr = addr;
        e.data = xorshift(rngState);
        e.mask = rnd[maskWidth-1:0];
        fits   = boosted ? (boostModel.size() < bankDepth) : (seqModel.size() < bankDepth);
        storeValid   = 1'b1;
        storeBoosted = boosted;
        storeAddr    = e.addr;
        storeData    = e.data;
        storeMask    = e.mask;
        @(posedge phi1);
        if (fits && boosted) boostModel.push_back(e);
        if (fits && !boosted) seqModel.push_back(e);
        @(negedge phi1);
        storeValid = 1'b0;
        compareFlag("memExcept after store", !fits, memExcept);
    endtask

    task automatic probeLoad(input logic boosted, input logic [addrWidth-1:0] addr);
        logic expConflict;
        logic expExcept;
        @(negedge phi1);
        expConflict = 1'b0;
        expExcept   = 1'b0;
        foreach (seqModel[k]) if (seqModel[k].addr == addr) expConflict = 1'b1;
        foreach (boostModel[k]) if (boosted && boostModel[k].addr == addr) expExcept = 1'b1;
        loadValid   = 1'b1;
        loadBoosted = boosted;
        loadAddr    = addr;
        @(posedge phi1);
        compareFlag("seqConflict", expConflict, seqConflict);
        @(negedge phi1);
        loadValid = 1'b0;
        compareFlag("memExcept after load", expExcept, memExcept);
    endtask

    // Commit stalls while the sequential bank still holds stores
    task automatic tryCommit();
        logic expStall;
        @(negedge phi1);
        expStall = (seqModel.size() != 0);
        commit   = 1'b1;
        @(posedge phi1);
        compareFlag("bufferStall", expStall, bufferStall);
        while (!expStall && boostModel.size() > 0) seqModel.push_back(boostModel.pop_front());
        @(negedge phi1);
        commit = 1'b0;
    endtask

    // A boosted store in the flush cycle goes down with the boosted bank
    task automatic flushBoost(input logic useExcept);
        @(negedge phi1);
        squash       = ~useExcept;
        except       = useExcept;
        storeValid   = 1'b1;
        storeBoosted = 1'b1;
        storeAddr    = xorshift(rngState);
        @(posedge phi1);
        boostModel.delete();
        @(negedge phi1);
        squash     = 1'b0;
        except     = 1'b0;
        storeValid = 1'b0;
        compareFlag("memExcept after flush", 1'b0, memExcept);
    endtask

    task automatic waitDrain(input int limit);
        int n;
        n = 0;
        while ((seqModel.size() != 0 || memWriteValid) && n < limit) begin
            @(negedge phi1);
            n++;
        end
        if (seqModel.size() != 0 || memWriteValid) begin
            $display("%s: timed out waiting for the sequential bank to drain", testName);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        monMark    = monErrors;
    endtask

    task automatic endTest();
        int n;
        n = testErrors + monErrors - monMark;
        testCount++;
        errors += n;
        if (n == 0) begin
            $display("[PASS] %s", testName);
        end else begin
            $display("[FAIL] %s with %0d errors", testName, n);
            failedTests++;
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic seqOrder();
        startTest("sequential order");
        readyLevel = 1'b1;
        repeat (3) pushStore(1'b0, xorshift(rngState));
        waitDrain(40);
        endTest();
    endtask

    // Boosted stores wait for a commit that finds the sequential bank empty
    task automatic commitRelease();
        startTest("commit");
        readyLevel = 1'b0;
        repeat (2) pushStore(1'b0, xorshift(rngState));
        repeat (2) pushStore(1'b1, xorshift(rngState));
        tryCommit();
        readyLevel = 1'b1;
        waitDrain(40);
        repeat (4) @(negedge phi1);
        compareFlag("memWriteValid before commit", 1'b0, memWriteValid);
        tryCommit();
        waitDrain(40);
        endTest();
    endtask

    task automatic dropBoosted(input logic useExcept);
        startTest(useExcept ? "exception" : "squash");
        readyLevel = 1'b0;
        repeat (2) pushStore(1'b0, xorshift(rngState));
        repeat (2) pushStore(1'b1, xorshift(rngState));
        flushBoost(useExcept);
        readyLevel = 1'b1;
        waitDrain(40);
        // Emptied bank turns sequential and has nothing to give
        tryCommit();
        repeat (4) @(negedge phi1);
        compareFlag("memWriteValid after flush", 1'b0, memWriteValid);
        endTest();
    endtask

    task automatic fullBank();
        startTest("full bank");
        readyLevel = 1'b0;
        repeat (5) pushStore(1'b0, xorshift(rngState));
        @(negedge phi1);
        compareFlag("memExcept second cycle", 1'b0, memExcept);
        readyLevel = 1'b1;
        waitDrain(40);
        endTest();
    endtask

    task automatic loadConflicts();
        logic [addrWidth-1:0] a;
        startTest("load conflicts");
        a = xorshift(rngState);
        readyLevel = 1'b0;
        pushStore(1'b0, a);
        pushStore(1'b1, a ^ 32'h100);
        probeLoad(1'b0, a);
        probeLoad(1'b1, a ^ 32'h100);
        probeLoad(1'b1, a ^ 32'h200);
        flushBoost(1'b0);
        readyLevel = 1'b1;
        waitDrain(40);
        endTest();
    endtask

    task automatic backPressure();
        startTest("back-pressure");
        jitter = 1'b1;
        repeat (12) pushStore(1'b0, xorshift(rngState));
        waitDrain(300);
        @(negedge phi1);
        jitter     = 1'b0;
        readyLevel = 1'b1;
        endTest();
    endtask

    initial begin
        rst = 1'b1;
        {stall, storeValid, storeBoosted, loadValid, loadBoosted} = '0;
        {commit, squash, except, readyLevel, jitter} = '0;
        storeAddr = '0;
        storeData = '0;
        storeMask = '0;
        loadAddr  = '0;
        repeat (2) @(posedge phi1);
        @(negedge phi1);
        rst = 1'b0;
        seqOrder();
        commitRelease();
        dropBoosted(1'b0);
        dropBoosted(1'b1);
        fullBank();
        loadConflicts();
        backPressure();
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 testCount, failedTests, errors, u_storeBufferTop.u_asserts.failCount);
        if (errors == 0 && u_storeBufferTop.u_asserts.failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/storeBufferGeomPkg.sv
source/storeBufferCtrlPkg.sv
source/storeRouter.sv
source/storeBufferBank.sv
source/retireSelect.sv
source/storeBufferTop.sv
tests/storeBuffer_asserts.sv
tests/storeBufferTb.sv

//--- Makefile
# Verilator build and run of the store buffer testbench

VERILATOR ?= verilator
TOP       ?= storeBufferTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

# Fails unless the pass message appears as a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
